//--- src.f
+incdir+testbench
source/cl_glue_pkg.sv
source/delay_pipe.sv
source/reset_tree.sv
source/host_ctl.sv
source/scrub_id_mux.sv
source/cl_glue_top.sv
testbench/tb_cl_glue.sv

//--- run.sh
#!/bin/sh
# Compile and run the cl_glue testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/10ps \
   --top-module tb_cl_glue -f src.f > build.log 2>&1 \
   || { cat build.log; echo "Verilator build failed"; exit 1; }

./obj_dir/Vtb_cl_glue > sim.log 2>&1 \
   || { cat sim.log; echo "Simulation exited with an error"; exit 1; }

cat sim.log
grep -q '\*\* FAIL \*\*' sim.log && { echo "Result: failed"; exit 1; } || echo "Result: passed"

//--- testbench/tb_cl_glue_tests.svh
// All stat, FLR and enable outputs must sit at zero
task automatic idle_outputs(input string when);
   compare_value(64'(cl_sh_flr_done), 64'd0, {when, ": flr done"});
   compare_value(64'(scrb_en), 64'd0, {when, ": scrb_en"});
   compare_value(64'(ddr_stat_wr), 64'd0, {when, ": ddr_stat_wr"});
   compare_value(64'(ddr_stat_rd), 64'd0, {when, ": ddr_stat_rd"});
   compare_value(64'(ddr_sh_stat_ack), 64'd0, {when, ": ddr_sh_stat_ack"});
   for (int k = 0; k < NUM_STAT_CH; k++)
   begin
      compare_value(64'(ddr_stat_addr[k]), 64'd0, $sformatf("%s: addr %0d", when, k));
      compare_value(64'(ddr_stat_wdata[k]), 64'd0, $sformatf("%s: wdata %0d", when, k));
      compare_value(64'(ddr_sh_stat_rdata[k]), 64'd0, $sformatf("%s: rdata %0d", when, k));
      compare_value(64'(ddr_sh_stat_int[k]), 64'd0, $sformatf("%s: int %0d", when, k));
   end
endtask

// --------------------
// Stat pipelines
// --------------------
// A write beat followed at once by a read beat on each channel
task automatic stat_request_path();
   stat_addr_t addr [2];
   stat_data_t data [2];
   stat_ch_t   exp_wr;
   stat_ch_t   exp_rd;
   int         beat;
   for (int k = 0; k < NUM_STAT_CH; k++)
   begin
      for (int b = 0; b < 2; b++)
      begin
         addr[b] = stat_addr_t'(random_word());
         data[b] = random_word();
      end
      @(negedge clk);
      sh_ddr_stat_wr[k]    = 1'b1;
      sh_ddr_stat_addr[k]  = addr[0];
      sh_ddr_stat_wdata[k] = data[0];
      for (int c = 1; c <= STAT_STAGES + 2; c++)
      begin
         @(negedge clk);
         if (c == 1)
         begin
            sh_ddr_stat_wr[k]    = 1'b0;
            sh_ddr_stat_rd[k]    = 1'b1;
            sh_ddr_stat_addr[k]  = addr[1];
            sh_ddr_stat_wdata[k] = data[1];
         end
         else if (c == 2)
         begin
            sh_ddr_stat_rd[k]    = 1'b0;
            sh_ddr_stat_addr[k]  = '0;
            sh_ddr_stat_wdata[k] = '0;
         end
         exp_wr = '0;
         exp_rd = '0;
         if (c == STAT_STAGES)
            exp_wr[k] = 1'b1;
         if (c == STAT_STAGES + 1)
            exp_rd[k] = 1'b1;
         compare_value(64'(ddr_stat_wr), 64'(exp_wr), $sformatf("ch %0d cyc %0d wr", k, c));
         compare_value(64'(ddr_stat_rd), 64'(exp_rd), $sformatf("ch %0d cyc %0d rd", k, c));
         if (c == STAT_STAGES || c == STAT_STAGES + 1)
         begin
            beat = c - STAT_STAGES;
            compare_value(64'(ddr_stat_addr[k]), 64'(addr[beat]),
                          $sformatf("ch %0d beat %0d addr", k, beat));
            compare_value(64'(ddr_stat_wdata[k]), 64'(data[beat]),
                          $sformatf("ch %0d beat %0d wdata", k, beat));
         end
      end
   end
endtask

task automatic stat_ack_path();
   stat_int_t  int_v;
   stat_data_t rdata;
   stat_ch_t   exp_ack;
   for (int k = 0; k < NUM_STAT_CH; k++)
   begin
      int_v = stat_int_t'(random_word());
      rdata = random_word();
      @(negedge clk);
      ddr_stat_ack[k]   = 1'b1;
      ddr_stat_int[k]   = int_v;
      ddr_stat_rdata[k] = rdata;
      for (int c = 1; c <= STAT_STAGES + 1; c++)
      begin
         @(negedge clk);
         if (c == 1)
         begin
            ddr_stat_ack[k]   = 1'b0;
            ddr_stat_int[k]   = '0;
            ddr_stat_rdata[k] = '0;
         end
         exp_ack = '0;
         if (c == STAT_STAGES)
            exp_ack[k] = 1'b1;
         compare_value(64'(ddr_sh_stat_ack), 64'(exp_ack), $sformatf("ch %0d cyc %0d ack", k, c));
         if (c == STAT_STAGES)
         begin
            compare_value(64'(ddr_sh_stat_int[k]), 64'(int_v), $sformatf("ch %0d int", k));
            compare_value(64'(ddr_sh_stat_rdata[k]), 64'(rdata), $sformatf("ch %0d rdata", k));
         end
      end
   end
endtask

// --------------------
// Host control
// --------------------
task automatic scrub_enable_map();
   ddr_mask_t exp_en [4];
   reg_word_t ctl;
   // Host bits A, B, D, C land on DDR mask bits 0, 1, 3, 2
   exp_en[0] = 4'b0001;
   exp_en[1] = 4'b0010;
   exp_en[2] = 4'b1000;
   exp_en[3] = 4'b0100;
   for (int i = 0; i < 4; i++)
   begin
      @(negedge clk);
      ctl        = '0;
      ctl[i]     = 1'b1;
      sh_cl_ctl0 = ctl;
      @(negedge clk);
      compare_value(64'(scrb_en), 64'(exp_en[i]), $sformatf("scrb_en for ctl bit %0d", i));
   end
   sh_cl_ctl0 = '0;
   @(negedge clk);
   compare_value(64'(scrb_en), 64'd0, "scrb_en after clear");
endtask

task automatic flr_ack_pulse();
   logic exp_done;
   @(negedge clk);
   sh_cl_flr_assert = 1'b1;
   for (int c = 1; c <= 6; c++)
   begin
      @(negedge clk);
      sh_cl_flr_assert = 1'b0;
      exp_done = (c == 2);
      compare_value(64'(cl_sh_flr_done), 64'(exp_done), $sformatf("flr pulse cyc %0d", c));
   end
   // Held request makes done toggle
   sh_cl_flr_assert = 1'b1;
   for (int c = 1; c <= 10; c++)
   begin
      @(negedge clk);
      exp_done = (c >= 2) && (c % 2 == 0);
      compare_value(64'(cl_sh_flr_done), 64'(exp_done), $sformatf("flr held cyc %0d", c));
   end
   sh_cl_flr_assert = 1'b0;
   repeat (3) @(negedge clk);
   compare_value(64'(cl_sh_flr_done), 64'd0, "flr done after release");
endtask

function automatic ddr_addr_t expected_dbg_addr(input logic [2:0] sel);
   case (sel)
      3'd1:    return scrb_addr_b;
      3'd2:    return scrb_addr_d;
      3'd3:    return scrb_addr_c;
      default: return scrb_addr_a;
   endcase
endfunction

task automatic id_mux_select();
   reg_word_t ctl;
   ddr_addr_t exp_addr;
   reg_word_t prev_exp0;
   reg_word_t prev_exp1;
   scrb_addr_a = {random_word(), random_word()};
   scrb_addr_b = {random_word(), random_word()};
   scrb_addr_c = {random_word(), random_word()};
   scrb_addr_d = {random_word(), random_word()};
   // Select field alone leaves the fixed IDs
   sh_cl_ctl0 = 32'h3000_0000;
   repeat (2) @(negedge clk);
   compare_value(64'(cl_sh_id0), 64'(ID0), "id0 debug off");
   compare_value(64'(cl_sh_id1), 64'(ID1), "id1 debug off");
   prev_exp0 = ID0;
   prev_exp1 = ID1;
   for (int s = 0; s < 8; s++)
   begin
      ctl        = '0;
      ctl[31]    = 1'b1;
      ctl[30:28] = 3'(s);
      sh_cl_ctl0 = ctl;
      exp_addr   = expected_dbg_addr(3'(s));
      @(negedge clk);
      compare_value(64'(cl_sh_id0), 64'(prev_exp0), $sformatf("id0 early, sel %0d", s));
      compare_value(64'(cl_sh_id1), 64'(prev_exp1), $sformatf("id1 early, sel %0d", s));
      @(negedge clk);
      compare_value(64'(cl_sh_id0), 64'(exp_addr[31:0]), $sformatf("id0 sel %0d", s));
      compare_value(64'(cl_sh_id1), 64'(exp_addr[63:32]), $sformatf("id1 sel %0d", s));
      prev_exp0 = exp_addr[31:0];
      prev_exp1 = exp_addr[63:32];
   end
   sh_cl_ctl0 = '0;
   repeat (2) @(negedge clk);
   compare_value(64'(cl_sh_id0), 64'(ID0), "id0 after debug");
   compare_value(64'(cl_sh_id1), 64'(ID1), "id1 after debug");
endtask

//--- testbench/tb_cl_glue.sv
`timescale 1ns/10ps

module tb_cl_glue
   import cl_glue_pkg::*;
();

   localparam int        CLK_PERIOD      = 100;
   localparam int        RST_CYCLES      = 16;
   localparam int        RST_STAGES      = 4;
   localparam int        STAT_STAGES     = 8;
   localparam reg_word_t ID0             = 32'hCAFE_0001;
   localparam reg_word_t ID1             = 32'h5EED_0D1E;
   localparam int        NUM_TESTS       = 6;
   localparam int        WATCHDOG_CYCLES = NUM_TESTS * 200 + 100;

   logic       clk;
   logic       sync_rst_n;
   logic       sh_cl_flr_assert;
   logic       cl_sh_flr_done;
   reg_word_t  sh_cl_ctl0;
   ddr_mask_t  scrb_en;
   reg_word_t  cl_sh_id0;
   reg_word_t  cl_sh_id1;
   ddr_addr_t  scrb_addr_a;
   ddr_addr_t  scrb_addr_b;
   ddr_addr_t  scrb_addr_c;
   ddr_addr_t  scrb_addr_d;
   stat_ch_t   sh_ddr_stat_wr;
   stat_ch_t   sh_ddr_stat_rd;
   stat_addr_t sh_ddr_stat_addr [NUM_STAT_CH];
   stat_data_t sh_ddr_stat_wdata [NUM_STAT_CH];
   stat_ch_t   ddr_sh_stat_ack;
   stat_data_t ddr_sh_stat_rdata [NUM_STAT_CH];
   stat_int_t  ddr_sh_stat_int [NUM_STAT_CH];
   stat_ch_t   ddr_stat_wr;
   stat_ch_t   ddr_stat_rd;
   stat_addr_t ddr_stat_addr [NUM_STAT_CH];
   stat_data_t ddr_stat_wdata [NUM_STAT_CH];
   stat_ch_t   ddr_stat_ack;
   stat_data_t ddr_stat_rdata [NUM_STAT_CH];
   stat_int_t  ddr_stat_int [NUM_STAT_CH];

   int     error_count = 0;
   int     check_count = 0;
   integer seed        = 64634;

   cl_glue_top #(
      .RST_PIPE_STAGES (RST_STAGES),
      .DDR_STAT_STAGES (STAT_STAGES),
      .CL_ID0          (ID0),
      .CL_ID1          (ID1)
   ) dut_i (.*);

   initial
   begin
      clk = 1'b0;
      forever
      begin
         #(CLK_PERIOD / 2) clk = ~clk;
      end
   end

   // --------------------
   // Watchdog
   // --------------------
   initial
   begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("Watchdog expired after %0d clock cycles, the tests did not finish",
               WATCHDOG_CYCLES);
      $display("** FAIL **");
      $finish;
   end

   task automatic compare_value(input logic [63:0] actual, input logic [63:0] expected,
                                input string what);
      check_count++;
      assert (actual === expected)
      else
      begin
         error_count++;
         $display("Error at %0t: %s is %0h, expected %0h", $time, what, actual, expected);
      end
   endtask

   function automatic logic [31:0] random_word();
      return $random(seed);
   endfunction

   `include "tb_cl_glue_tests.svh"

   // --------------------
   // Test sequence
   // --------------------
   initial
   begin
      sync_rst_n       = 1'b0;
      sh_cl_flr_assert = 1'b0;
      sh_cl_ctl0       = '0;
      scrb_addr_a      = '0;
      scrb_addr_b      = '0;
      scrb_addr_c      = '0;
      scrb_addr_d      = '0;
      sh_ddr_stat_wr   = '0;
      sh_ddr_stat_rd   = '0;
      ddr_stat_ack     = '0;
      for (int k = 0; k < NUM_STAT_CH; k++)
      begin
         sh_ddr_stat_addr[k]  = '0;
         sh_ddr_stat_wdata[k] = '0;
         ddr_stat_rdata[k]    = '0;
         ddr_stat_int[k]      = '0;
      end

      repeat (RST_CYCLES) @(negedge clk);
      idle_outputs("in reset");
      sync_rst_n = 1'b1;
      // Two synchronizer clocks, then the per-block reset pipes
      repeat (RST_STAGES + 3) @(negedge clk);
      idle_outputs("after reset");

      stat_request_path();
      stat_ack_path();
      scrub_enable_map();
      flr_ack_pulse();
      id_mux_select();

      @(negedge clk);
      $display("Checks: %0d, errors: %0d", check_count, error_count);
      if (error_count == 0)
      begin
         $display("** PASS **");
      end
      else
      begin
         $display("** FAIL **");
      end
      $finish;
   end

endmodule

//--- source/cl_glue_top.sv
`timescale 1ns/10ps

module cl_glue_top
   import cl_glue_pkg::*;
#(
   parameter int        RST_PIPE_STAGES = 4,
   parameter int        DDR_STAT_STAGES = 8,
   parameter reg_word_t CL_ID0          = 32'hF000_1D0F,
   parameter reg_word_t CL_ID1          = 32'h1D51_FEDD
) (
   input  logic       clk,
   input  logic       sync_rst_n,

   // Host control and status
   input  logic       sh_cl_flr_assert,
   output logic       cl_sh_flr_done,
   input  reg_word_t  sh_cl_ctl0,
   output ddr_mask_t  scrb_en,
   output reg_word_t  cl_sh_id0,
   output reg_word_t  cl_sh_id1,

   // Scrubber progress
   input  ddr_addr_t  scrb_addr_a,
   input  ddr_addr_t  scrb_addr_b,
   input  ddr_addr_t  scrb_addr_c,
   input  ddr_addr_t  scrb_addr_d,

   // Stat channels, shell side
   input  stat_ch_t   sh_ddr_stat_wr,
   input  stat_ch_t   sh_ddr_stat_rd,
   input  stat_addr_t sh_ddr_stat_addr [NUM_STAT_CH],
   input  stat_data_t sh_ddr_stat_wdata [NUM_STAT_CH],
   output stat_ch_t   ddr_sh_stat_ack,
   output stat_data_t ddr_sh_stat_rdata [NUM_STAT_CH],
   output stat_int_t  ddr_sh_stat_int [NUM_STAT_CH],

   // Stat channels, controller side
   output stat_ch_t   ddr_stat_wr,
   output stat_ch_t   ddr_stat_rd,
   output stat_addr_t ddr_stat_addr [NUM_STAT_CH],
   output stat_data_t ddr_stat_wdata [NUM_STAT_CH],
   input  stat_ch_t   ddr_stat_ack,
   input  stat_data_t ddr_stat_rdata [NUM_STAT_CH],
   input  stat_int_t  ddr_stat_int [NUM_STAT_CH]
);

   logic      ctl_rst_n;
   logic      stat_rst_n;
   reg_word_t ctl_q;

   // --------------------
   // Resets
   // --------------------
   reset_tree #(
      .RST_PIPE_STAGES (RST_PIPE_STAGES)
   ) reset_tree_i (
      .clk        (clk),
      .sync_rst_n (sync_rst_n),
      .ctl_rst_n  (ctl_rst_n),
      .stat_rst_n (stat_rst_n)
   );

   // --------------------
   // Host control
   // --------------------
   host_ctl host_ctl_i (
      .clk              (clk),
      .ctl_rst_n        (ctl_rst_n),
      .sh_cl_ctl0       (sh_cl_ctl0),
      .sh_cl_flr_assert (sh_cl_flr_assert),
      .ctl_q            (ctl_q),
      .scrb_en          (scrb_en),
      .cl_sh_flr_done   (cl_sh_flr_done)
   );

   scrub_id_mux #(
      .CL_ID0 (CL_ID0),
      .CL_ID1 (CL_ID1)
   ) scrub_id_mux_i (
      .clk         (clk),
      .ctl_q       (ctl_q),
      .scrb_addr_a (scrb_addr_a),
      .scrb_addr_b (scrb_addr_b),
      .scrb_addr_c (scrb_addr_c),
      .scrb_addr_d (scrb_addr_d),
      .cl_sh_id0   (cl_sh_id0),
      .cl_sh_id1   (cl_sh_id1)
   );

   // --------------------
   // Stat pipelines
   // --------------------
   // Retiming stages between the shell and the DDR controller
   for (genvar k = 0; k < NUM_STAT_CH; k++)
   begin : g_stat
      delay_pipe #(
         .WIDTH  (STAT_REQ_W),
         .STAGES (DDR_STAT_STAGES)
      ) req_pipe (
         .clk     (clk),
         .rst_n   (stat_rst_n),
         .in_bus  ({sh_ddr_stat_wr[k], sh_ddr_stat_rd[k],
                    sh_ddr_stat_addr[k], sh_ddr_stat_wdata[k]}),
         .out_bus ({ddr_stat_wr[k], ddr_stat_rd[k],
                    ddr_stat_addr[k], ddr_stat_wdata[k]})
      );

      delay_pipe #(
         .WIDTH  (STAT_ACK_W),
         .STAGES (DDR_STAT_STAGES)
      ) ack_pipe (
         .clk     (clk),
         .rst_n   (stat_rst_n),
         .in_bus  ({ddr_stat_ack[k], ddr_stat_int[k], ddr_stat_rdata[k]}),
         .out_bus ({ddr_sh_stat_ack[k], ddr_sh_stat_int[k], ddr_sh_stat_rdata[k]})
      );
   end

endmodule

//--- source/scrub_id_mux.sv
`timescale 1ns/10ps

module scrub_id_mux
   import cl_glue_pkg::*;
#(
   parameter reg_word_t CL_ID0 = 32'hF000_1D0F,
   parameter reg_word_t CL_ID1 = 32'h1D51_FEDD
) (
   input  logic      clk,
   input  reg_word_t ctl_q,
   input  ddr_addr_t scrb_addr_a,
   input  ddr_addr_t scrb_addr_b,
   input  ddr_addr_t scrb_addr_c,
   input  ddr_addr_t scrb_addr_d,
   output reg_word_t cl_sh_id0,
   output reg_word_t cl_sh_id1
);

   logic                 dbg_en;
   logic [DBG_SEL_W-1:0] dbg_sel;
   ddr_addr_t            dbg_addr;

   assign dbg_en  = ctl_q[CTL_DBG_EN_BIT];
   assign dbg_sel = ctl_q[CTL_DBG_SEL_LSB +: DBG_SEL_W];

   // Pick the scrubber to watch
   always_comb
   begin
      case (dbg_sel)
         DBG_SEL_B: dbg_addr = scrb_addr_b;
         DBG_SEL_D: dbg_addr = scrb_addr_d;
         DBG_SEL_C: dbg_addr = scrb_addr_c;
         default:   dbg_addr = scrb_addr_a;
      endcase
   end

   // --------------------
   // ID outputs
   // --------------------
   // Low address half on ID0, high half on ID1 while debugging
   always_ff @(posedge clk)
   begin
      if (dbg_en)
      begin
         cl_sh_id0 <= dbg_addr[REG_W-1:0];
         cl_sh_id1 <= dbg_addr[ADDR_W-1:REG_W];
      end
      else
      begin
         cl_sh_id0 <= CL_ID0;
         cl_sh_id1 <= CL_ID1;
      end
   end

endmodule

//--- source/host_ctl.sv
`timescale 1ns/10ps

module host_ctl
   import cl_glue_pkg::*;
(
   input  logic      clk,
   input  logic      ctl_rst_n,
   input  reg_word_t sh_cl_ctl0,
   input  logic      sh_cl_flr_assert,
   output reg_word_t ctl_q,
   output ddr_mask_t scrb_en,
   output logic      cl_sh_flr_done
);

   logic flr_assert_q;

   // --------------------
   // Control word
   // --------------------
   always_ff @(posedge clk or negedge ctl_rst_n)
   begin
      if (!ctl_rst_n)
      begin
         ctl_q <= '0;
      end
      else
      begin
         ctl_q <= sh_cl_ctl0;
      end
   end

   // Host bit order differs from DDR index order for C and D
   assign scrb_en[DDR_A] = ctl_q[CTL_EN_BIT_A];
   assign scrb_en[DDR_B] = ctl_q[CTL_EN_BIT_B];
   assign scrb_en[DDR_C] = ctl_q[CTL_EN_BIT_C];
   assign scrb_en[DDR_D] = ctl_q[CTL_EN_BIT_D];

   // --------------------
   // FLR acknowledge
   // --------------------
   // Done pulses one cycle after the registered request, then clears itself
   always_ff @(posedge clk or negedge ctl_rst_n)
   begin
      if (!ctl_rst_n)
      begin
         flr_assert_q   <= 1'b0;
         cl_sh_flr_done <= 1'b0;
      end
      else
      begin
         flr_assert_q   <= sh_cl_flr_assert;
         cl_sh_flr_done <= flr_assert_q && !cl_sh_flr_done;
      end
   end

endmodule

//--- source/reset_tree.sv
`timescale 1ns/10ps

module reset_tree #(
   parameter int RST_PIPE_STAGES = 4
) (
   input  logic clk,
   input  logic sync_rst_n,
   output logic ctl_rst_n,
   output logic stat_rst_n
);

   logic pre_rst_n_q;
   logic core_rst_n_q;

   // --------------------
   // Release synchronizer
   // --------------------
   // Asserts at once, releases two clocks after sync_rst_n goes high
   always_ff @(posedge clk or negedge sync_rst_n)
   begin
      if (!sync_rst_n)
      begin
         pre_rst_n_q  <= 1'b0;
         core_rst_n_q <= 1'b0;
      end
      else
      begin
         pre_rst_n_q  <= 1'b1;
         core_rst_n_q <= pre_rst_n_q;
      end
   end

   // --------------------
   // Per-block copies
   // --------------------
   // Separate pipes so each block's reset net can be placed near it
   delay_pipe #(
      .WIDTH  (1),
      .STAGES (RST_PIPE_STAGES)
   ) ctl_rst_pipe (
      .clk     (clk),
      .rst_n   (1'b1),
      .in_bus  (core_rst_n_q),
      .out_bus (ctl_rst_n)
   );

   delay_pipe #(
      .WIDTH  (1),
      .STAGES (RST_PIPE_STAGES)
   ) stat_rst_pipe (
      .clk     (clk),
      .rst_n   (1'b1),
      .in_bus  (core_rst_n_q),
      .out_bus (stat_rst_n)
   );

endmodule

//--- source/delay_pipe.sv
`timescale 1ns/10ps

module delay_pipe #(
   parameter int WIDTH  = 1,
   parameter int STAGES = 1
) (
   input  logic             clk,
   input  logic             rst_n,
   input  logic [WIDTH-1:0] in_bus,
   output logic [WIDTH-1:0] out_bus
);

   // Stage 0 takes the input, the last stage drives the output
   logic [WIDTH-1:0] stage_q [STAGES];

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         for (int i = 0; i < STAGES; i++)
         begin
            stage_q[i] <= '0;
         end
      end
      else
      begin
         stage_q[0] <= in_bus;
         for (int i = 1; i < STAGES; i++)
         begin
            stage_q[i] <= stage_q[i-1];
         end
      end
   end

   assign out_bus = stage_q[STAGES-1];

endmodule

//--- source/cl_glue_pkg.sv
package cl_glue_pkg;

   // --------------------
   // Widths
   // --------------------
   localparam int NUM_DDR     = 4;
   localparam int NUM_STAT_CH = 3;
   localparam int REG_W       = 32;
   localparam int ADDR_W      = 64;
   localparam int DBG_SEL_W   = 3;

   typedef logic [REG_W-1:0]       reg_word_t;
   typedef logic [ADDR_W-1:0]      ddr_addr_t;
   typedef logic [7:0]             stat_addr_t;
   typedef logic [31:0]            stat_data_t;
   typedef logic [7:0]             stat_int_t;
   typedef logic [NUM_DDR-1:0]     ddr_mask_t;
   typedef logic [NUM_STAT_CH-1:0] stat_ch_t;

   // Stat request is {wr, rd, addr, wdata}, ack is {ack, int, rdata}
   localparam int STAT_REQ_W = 2 + $bits(stat_addr_t) + $bits(stat_data_t);
   localparam int STAT_ACK_W = 1 + $bits(stat_int_t) + $bits(stat_data_t);

   // DDR positions in ddr_mask_t
   localparam int DDR_A = 0;
   localparam int DDR_B = 1;
   localparam int DDR_C = 2;
   localparam int DDR_D = 3;

   // --------------------
   // Control word layout
   // --------------------
   // Enable bits, D sits below C in the host word
   localparam int CTL_EN_BIT_A    = 0;
   localparam int CTL_EN_BIT_B    = 1;
   localparam int CTL_EN_BIT_D    = 2;
   localparam int CTL_EN_BIT_C    = 3;
   localparam int CTL_DBG_EN_BIT  = 31;
   localparam int CTL_DBG_SEL_LSB = 28;

   // Debug memory select codes, anything else picks DDR A
   localparam logic [DBG_SEL_W-1:0] DBG_SEL_B = 3'd1;
   localparam logic [DBG_SEL_W-1:0] DBG_SEL_D = 3'd2;
   localparam logic [DBG_SEL_W-1:0] DBG_SEL_C = 3'd3;

endpackage
